// ==== include/video_settings.svh ====
// Screen geometry and sync positions
// Pixel pipeline latency of the tile layer
// CPU address map and palette size
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Totals include blanking
`define H_TOTAL     64
`define H_ACTIVE    48
`define HS_START    52
`define HS_END      56
`define V_TOTAL     40
`define V_ACTIVE    32
`define VS_START    35
`define VS_END      37

// 8x8 tile map, one byte per cell
`define MAP_CELLS   64
// Pixel clocks from beam to layer output
`define PXL_LATENCY 8

// CPU address map, 10-bit byte addresses
`define REG_BASE    10'h000
`define REG_COUNT   5
`define MAP_BASE    10'h200
`define PAL_BASE    10'h300
`define PAL_ENTRIES 32

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module video_tb \
    -f verilog.f -o vvideo_tb

./obj_dir/vvideo_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== src/color_mix.sv ====
// Colour mixer
// Byte-wide CPU palette RAM, index selection, RGB555 widening and blanking
`timescale 1ns/1ns
`include "video_settings.svh"

module color_mix(
    input                       clk,
    input                       reset,
    input                       pxl_cen,
    input  video_pkg::beam_t    beam,
    input  video_pkg::bus_req_t req,
    output logic [7:0]          pal_rdata,
    input        [3:0]          pxl,
    input                       layer_en,
    input                       pal_bank,
    input        [4:0]          backdrop,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue
);
    import video_pkg::*;

    localparam int PW = $clog2(`PAL_ENTRIES);

    // Even byte holds the upper half of an entry
    logic [7:0]    pal_hi [`PAL_ENTRIES];
    logic [7:0]    pal_lo [`PAL_ENTRIES];
    logic [PW:0]   cpu_a;
    logic          pal_sel;
    logic [PW-1:0] idx;
    logic [15:0]   entry;

    function automatic logic [7:0] widen(input logic [4:0] c);
        widen = {c, c[4:2]};
    endfunction

    assign cpu_a   = req.addr[PW:0];
    assign pal_sel = req.stb && (req.region == PAL_REGION);

    always_ff @(posedge clk) begin
        if (pal_sel) begin
            if (req.we && !cpu_a[0]) begin
                pal_hi[cpu_a[PW:1]] <= req.wdata;
            end
            if (req.we && cpu_a[0]) begin
                pal_lo[cpu_a[PW:1]] <= req.wdata;
            end
            pal_rdata <= cpu_a[0] ? pal_lo[cpu_a[PW:1]] : pal_hi[cpu_a[PW:1]];
        end
    end

    // Pen 0 of the layer is transparent
    always_comb begin
        if (layer_en && pxl != 4'd0) begin
            idx = {pal_bank, pxl};
        end else begin
            idx = backdrop;
        end
        entry = {pal_hi[idx], pal_lo[idx]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= 8'd0;
            green <= 8'd0;
            blue  <= 8'd0;
        end else if (pxl_cen) begin
            if (beam.lhbl && beam.lvbl) begin
                red   <= widen(entry[14:10]);
                green <= widen(entry[9:5]);
                blue  <= widen(entry[4:0]);
            end else begin
                red   <= 8'd0;
                green <= 8'd0;
                blue  <= 8'd0;
            end
        end
    end

endmodule

// ==== src/tile_layer.sv ====
// Scrolling tile layer
// Tile map RAM, fetch FSM with ROM handshake, double-buffered pixel shifter
`timescale 1ns/1ns
`include "video_settings.svh"

module tile_layer(
    input                       clk,
    input                       reset,
    input                       pxl_cen,
    input  video_pkg::beam_t    beam,
    input  video_pkg::bus_req_t req,
    output logic [7:0]          map_rdata,
    input        [5:0]          scroll_x,
    input        [5:0]          scroll_y,
    output                      rom_cs,
    output       [10:0]         rom_addr,
    input        [31:0]         rom_data,
    input                       rom_ok,
    output       [3:0]          pxl
);
    import video_pkg::*;

    logic [7:0]   map_ram [`MAP_CELLS];
    fetch_state_e state;
    logic [5:0]   sx;
    logic [5:0]   nx;
    logic [5:0]   sy;
    logic [8:0]   vf;
    logic         tile_edge;
    logic [5:0]   cell_q;
    logic [2:0]   row_q;
    logic [2:0]   row_f;
    logic [7:0]   code_q;
    logic [31:0]  data_q;
    logic [31:0]  buf_q;
    logic [31:0]  shift_q;
    logic         buf_valid;
    logic         fetch_go;
    logic         stale;

    // CPU port of the map
    always_ff @(posedge clk) begin
        if (req.stb && req.region == MAP_REGION) begin
            if (req.we) begin
                map_ram[req.addr[5:0]] <= req.wdata;
            end
            map_rdata <= map_ram[req.addr[5:0]];
        end
    end

    // Scrolled position, tile boundary one pixel ahead of the shifter
    assign sx        = beam.hdump[5:0] + scroll_x;
    assign nx        = sx + 6'd1;
    assign tile_edge = pxl_cen && (sx[2:0] == 3'd7);

    // During hblank fetch for the next line
    always_comb begin
        if (beam.hdump >= 9'(`H_ACTIVE)) begin
            vf = (beam.vdump == 9'(`V_TOTAL - 1)) ? 9'd0 : beam.vdump + 9'd1;
        end else begin
            vf = beam.vdump;
        end
        sy = vf[5:0] + scroll_y;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            fetch_go  <= 1'b0;
            stale     <= 1'b0;
            buf_valid <= 1'b0;
            shift_q   <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (fetch_go) begin
                        fetch_go <= 1'b0;
                        stale    <= 1'b0;
                        state    <= FETCH_MAP;
                    end
                end
                FETCH_MAP:  state <= FETCH_ROM;
                FETCH_ROM: begin
                    if (rom_ok) begin
                        state <= FETCH_LOAD;
                    end
                end
                FETCH_LOAD: begin
                    buf_valid <= ~stale;
                    state     <= FETCH_IDLE;
                end
                default:    state <= FETCH_IDLE;
            endcase
            // Tile slot boundary takes priority over a late load
            if (tile_edge) begin
                shift_q   <= buf_valid ? buf_q : '0;
                buf_valid <= 1'b0;
                fetch_go  <= 1'b1;
                if (state != FETCH_IDLE) begin
                    stale <= 1'b1;
                end
            end else if (pxl_cen) begin
                shift_q <= {shift_q[27:0], 4'd0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_edge) begin
            cell_q <= {sy[5:3], nx[5:3]};
            row_q  <= sy[2:0];
        end
        if (state == FETCH_MAP) begin
            code_q <= map_ram[cell_q];
            row_f  <= row_q;
        end
        if (state == FETCH_ROM && rom_ok) begin
            data_q <= rom_data;
        end
        if (state == FETCH_LOAD) begin
            buf_q <= data_q;
        end
    end

    // Address held steady for the whole request
    assign rom_cs   = (state == FETCH_ROM);
    assign rom_addr = {code_q, row_f};
    assign pxl      = shift_q[31:28];

endmodule

// ==== src/video_pkg.sv ====
// Shared types of the video subsystem
// Beam position, decoded CPU access, control registers, FSM states

package video_pkg;

    typedef enum logic [1:0] {
        REG_REGION,
        MAP_REGION,
        PAL_REGION,
        NO_REGION
    } region_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_ROM,
        FETCH_LOAD
    } fetch_state_e;

    // Blanking signals are high while the beam is visible
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } beam_t;

    // Address is an offset inside the region
    typedef struct packed {
        region_e    region;
        logic [9:0] addr;
        logic [7:0] wdata;
        logic       we;
        logic       stb;
    } bus_req_t;

    typedef struct packed {
        logic [5:0] scroll_x;
        logic [5:0] scroll_y;
        logic       layer_en;
        logic       irq_en;
        logic       pal_bank;
        logic [4:0] backdrop;
    } video_ctrl_t;

endpackage

// ==== src/video_regs.sv ====
// Wishbone classic slave of the video block
// Region decode, control registers, read mux, vblank interrupt
`timescale 1ns/1ns
`include "video_settings.svh"

module video_regs(
    input                          clk,
    input                          reset,
    input                          wb_cyc,
    input                          wb_stb,
    input                          wb_we,
    input        [9:0]             wb_adr,
    input        [7:0]             wb_dat_w,
    output logic [7:0]             wb_dat_r,
    output logic                   wb_ack,
    input  video_pkg::beam_t       beam,
    input        [7:0]             map_rdata,
    input        [7:0]             pal_rdata,
    output video_pkg::bus_req_t    req,
    output video_pkg::video_ctrl_t ctrl,
    output                         irq_n
);
    import video_pkg::*;

    logic [7:0] reg_rdata;
    region_e    rd_region;
    logic       vbl_pend;
    logic       lvbl_l;
    logic       reg_wr;

    // Access strobe is cut by the ack so each cycle is served once
    always_comb begin
        req       = '0;
        req.wdata = wb_dat_w;
        req.we    = wb_we;
        req.stb   = wb_cyc & wb_stb & ~wb_ack;
        if (wb_adr >= `PAL_BASE) begin
            req.region = PAL_REGION;
            req.addr   = wb_adr - `PAL_BASE;
        end else if (wb_adr >= `MAP_BASE) begin
            req.region = MAP_REGION;
            req.addr   = wb_adr - `MAP_BASE;
        end else if (wb_adr - `REG_BASE < 10'(`REG_COUNT)) begin
            req.region = REG_REGION;
            req.addr   = wb_adr - `REG_BASE;
        end else begin
            req.region = NO_REGION;
            req.addr   = wb_adr;
        end
    end

    assign reg_wr = req.stb & req.we & (req.region == REG_REGION);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            rd_region <= NO_REGION;
        end else begin
            wb_ack <= wb_cyc & wb_stb & ~wb_ack;
            if (req.stb) begin
                rd_region <= req.region;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.stb) begin
            case (req.addr[2:0])
                3'd0:    reg_rdata <= {5'd0, ctrl.pal_bank, ctrl.irq_en, ctrl.layer_en};
                3'd1:    reg_rdata <= {2'd0, ctrl.scroll_x};
                3'd2:    reg_rdata <= {2'd0, ctrl.scroll_y};
                3'd3:    reg_rdata <= {3'd0, ctrl.backdrop};
                default: reg_rdata <= {7'd0, vbl_pend};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl     <= '0;
            vbl_pend <= 1'b0;
            lvbl_l   <= 1'b1;
        end else begin
            lvbl_l <= beam.lvbl;
            if (reg_wr) begin
                case (req.addr[2:0])
                    3'd0: begin
                        ctrl.layer_en <= req.wdata[0];
                        ctrl.irq_en   <= req.wdata[1];
                        ctrl.pal_bank <= req.wdata[2];
                    end
                    3'd1:    ctrl.scroll_x <= req.wdata[5:0];
                    3'd2:    ctrl.scroll_y <= req.wdata[5:0];
                    3'd3:    ctrl.backdrop <= req.wdata[4:0];
                    // Any write to status acknowledges the interrupt
                    3'd4:    vbl_pend <= 1'b0;
                    default: ;
                endcase
            end
            // A new vblank wins over a clear in the same cycle
            if (lvbl_l && !beam.lvbl) begin
                vbl_pend <= 1'b1;
            end
        end
    end

    // Read byte arrives with the ack
    always_comb begin
        case (rd_region)
            REG_REGION: wb_dat_r = reg_rdata;
            MAP_REGION: wb_dat_r = map_rdata;
            PAL_REGION: wb_dat_r = pal_rdata;
            default:    wb_dat_r = 8'd0;
        endcase
    end

    assign irq_n = ~(vbl_pend & ctrl.irq_en);

endmodule

// ==== src/video_timing.sv ====
// Beam timing generator
// Pixel and line counters, blanking and sync decode
`timescale 1ns/1ns
`include "video_settings.svh"

module video_timing(
    input                    clk,
    input                    reset,
    input                    pxl_cen,
    output video_pkg::beam_t beam
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;

    // Line advances when the pixel counter wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= 9'd0;
            vcnt <= 9'd0;
        end else if (pxl_cen) begin
            if (hcnt == 9'(`H_TOTAL - 1)) begin
                hcnt <= 9'd0;
                if (vcnt == 9'(`V_TOTAL - 1)) begin
                    vcnt <= 9'd0;
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Decode straight from the counters so all fields change together
    always_comb begin
        beam.hdump = hcnt;
        beam.vdump = vcnt;
        beam.lhbl  = hcnt < 9'(`H_ACTIVE);
        beam.lvbl  = vcnt < 9'(`V_ACTIVE);
        beam.hs    = (hcnt >= 9'(`HS_START)) && (hcnt < 9'(`HS_END));
        beam.vs    = (vcnt >= 9'(`VS_START)) && (vcnt < 9'(`VS_END));
    end

endmodule

// ==== src/video_top.sv ====
// Video subsystem top level
// Timing, register block, tile layer and colour mixer with beam delay line
`timescale 1ns/1ns
`include "video_settings.svh"

module video_top(
    input               clk,
    input               reset,
    input               pxl_cen,
    // Wishbone slave
    input               wb_cyc,
    input               wb_stb,
    input               wb_we,
    input        [9:0]  wb_adr,
    input        [7:0]  wb_dat_w,
    output       [7:0]  wb_dat_r,
    output              wb_ack,
    output              irq_n,
    // Tile ROM
    output              rom_cs,
    output       [10:0] rom_addr,
    input        [31:0] rom_data,
    input               rom_ok,
    // Video out
    output       [7:0]  red,
    output       [7:0]  green,
    output       [7:0]  blue,
    output              lhbl,
    output              lvbl,
    output              hs,
    output              vs
);
    import video_pkg::*;

    beam_t       beam;
    beam_t       beam_mix;
    beam_t       beam_out;
    beam_t       beam_dly [`PXL_LATENCY + 1];
    bus_req_t    req;
    video_ctrl_t ctrl;
    logic [7:0]  map_rdata;
    logic [7:0]  pal_rdata;
    logic [3:0]  pxl;

    // Mixer sees the beam of the layer output, outputs one pixel later
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i <= `PXL_LATENCY; i++) begin
                beam_dly[i] <= '0;
            end
        end else if (pxl_cen) begin
            beam_dly[0] <= beam;
            for (int i = 1; i <= `PXL_LATENCY; i++) begin
                beam_dly[i] <= beam_dly[i-1];
            end
        end
    end

    assign beam_mix = beam_dly[`PXL_LATENCY - 1];
    assign beam_out = beam_dly[`PXL_LATENCY];
    assign lhbl     = beam_out.lhbl;
    assign lvbl     = beam_out.lvbl;
    assign hs       = beam_out.hs;
    assign vs       = beam_out.vs;

    video_timing u_timing(
        .clk      ( clk       ),
        .reset    ( reset     ),
        .pxl_cen  ( pxl_cen   ),
        .beam     ( beam      )
    );

    // Interrupt follows the blanking seen at the outputs
    video_regs u_regs(
        .clk      ( clk       ),
        .reset    ( reset     ),
        .wb_cyc   ( wb_cyc    ),
        .wb_stb   ( wb_stb    ),
        .wb_we    ( wb_we     ),
        .wb_adr   ( wb_adr    ),
        .wb_dat_w ( wb_dat_w  ),
        .wb_dat_r ( wb_dat_r  ),
        .wb_ack   ( wb_ack    ),
        .beam     ( beam_out  ),
        .map_rdata( map_rdata ),
        .pal_rdata( pal_rdata ),
        .req      ( req       ),
        .ctrl     ( ctrl      ),
        .irq_n    ( irq_n     )
    );

    tile_layer u_layer(
        .clk      ( clk           ),
        .reset    ( reset         ),
        .pxl_cen  ( pxl_cen       ),
        .beam     ( beam          ),
        .req      ( req           ),
        .map_rdata( map_rdata     ),
        .scroll_x ( ctrl.scroll_x ),
        .scroll_y ( ctrl.scroll_y ),
        .rom_cs   ( rom_cs        ),
        .rom_addr ( rom_addr      ),
        .rom_data ( rom_data      ),
        .rom_ok   ( rom_ok        ),
        .pxl      ( pxl           )
    );

    color_mix u_colmix(
        .clk      ( clk           ),
        .reset    ( reset         ),
        .pxl_cen  ( pxl_cen       ),
        .beam     ( beam_mix      ),
        .req      ( req           ),
        .pal_rdata( pal_rdata     ),
        .pxl      ( pxl           ),
        .layer_en ( ctrl.layer_en ),
        .pal_bank ( ctrl.pal_bank ),
        .backdrop ( ctrl.backdrop ),
        .red      ( red           ),
        .green    ( green         ),
        .blue     ( blue          )
    );

endmodule

// ==== tests/video_chk.sv ====
// Concurrent assertions on the video top level
// Bus acknowledge length, ROM request hold, one sync pulse per line
`timescale 1ns/1ns
`include "video_settings.svh"

module video_chk(
    input                   clk,
    input                   reset,
    input                   pxl_cen,
    input                   wb_ack,
    input                   rom_cs,
    input                   rom_ok,
    input            [10:0] rom_addr,
    input video_pkg::beam_t beam
);

    logic       hs_q;
    logic [1:0] hs_cnt;
    logic       line_end;

    // Last pixel of the line, the counter wraps on this clk
    assign line_end = pxl_cen && (beam.hdump == 9'(`H_TOTAL - 1));

    // Rising edges of hs seen during the current line
    always_ff @(posedge clk) begin
        if (reset) begin
            hs_q   <= 1'b0;
            hs_cnt <= 2'd0;
        end else begin
            hs_q <= beam.hs;
            if (line_end) begin
                hs_cnt <= 2'd0;
            end else if (beam.hs && !hs_q && hs_cnt != 2'd3) begin
                hs_cnt <= hs_cnt + 2'd1;
            end
        end
    end

    // Acknowledge is a single cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

    rom_hold: assert property (@(posedge clk) disable iff (reset)
        (rom_cs && !rom_ok) |=> rom_cs && $stable(rom_addr))
        else $error("rom_cs or rom_addr changed before rom_ok");

    hs_once: assert property (@(posedge clk) disable iff (reset)
        line_end |-> hs_cnt == 2'd1)
        else $error("hs did not pulse exactly once in the line");

endmodule

bind video_top video_chk chk_i(
    .clk      ( clk      ),
    .reset    ( reset    ),
    .pxl_cen  ( pxl_cen  ),
    .wb_ack   ( wb_ack   ),
    .rom_cs   ( rom_cs   ),
    .rom_ok   ( rom_ok   ),
    .rom_addr ( rom_addr ),
    .beam     ( beam     )
);

// ==== tests/video_monitor.sv ====
// Checker of the video testbench
// Bus acknowledge and read data, pixel colour and blanking, sync, interrupt line
`timescale 1ns/1ns
`include "video_settings.svh"

module video_monitor(
    input        clk,
    input        wb_cyc,
    input        wb_stb,
    input        wb_ack,
    input [7:0]  wb_dat_r,
    input        irq_n,
    input [7:0]  red,
    input [7:0]  green,
    input [7:0]  blue,
    input        lhbl,
    input        lvbl,
    input        hs,
    input        vs,
    input        exp_rd,
    input [7:0]  exp_data,
    input        col_check,
    input [23:0] exp_rgb,
    input        irq_hi_check
);

    int   errors = 0;
    int   checks = 0;
    int   tests = 0;
    int   line_cnt = 0;
    int   hclk = 0;
    int   vline = 0;
    logic req_seen = 1'b0;
    logic col_q = 1'b0;
    logic irq_q = 1'b0;
    logic armed = 1'b0;
    logic hknown = 1'b0;
    logic vknown = 1'b0;
    logic exp_hs;
    logic exp_vs;
    logic lhbl_q = 1'b1;
    logic lvbl_q = 1'b1;
    logic irq_n_q = 1'b1;

    task automatic note_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        errors++;
    endtask

    task automatic end_test(input int tag);
        tests++;
        $display("Test %0d finished, errors so far %0d", tag, errors);
    endtask

    task automatic report();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

    always @(posedge clk) begin
        req_seen <= wb_cyc & wb_stb & ~wb_ack;
        col_q    <= col_check;
        irq_q    <= irq_hi_check;
    end

    // Outputs change on the rising edge, sampled on the falling one
    always @(negedge clk) begin
        if (req_seen && !wb_ack) begin
            note_failure("wb_ack missing one cycle after the strobe");
        end else if (wb_ack && !req_seen) begin
            note_failure("wb_ack without a pending request");
        end
        if (wb_ack && exp_rd) begin
            checks++;
            if (wb_dat_r !== exp_data) begin
                $display("Error at %0t ns: read %h, expected %h", $time, wb_dat_r, exp_data);
                errors++;
            end
        end
        if (irq_q && irq_n !== 1'b1) begin
            $display("Error at %0t ns: irq_n still low after status write", $time);
            errors++;
        end
        if (irq_n_q && !irq_n && lvbl) begin
            $display("Error at %0t ns: irq_n fell outside vertical blank", $time);
            errors++;
        end
        if (!col_q) begin
            armed = 1'b0;
        end
        if (lvbl && !lvbl_q) begin
            line_cnt = 0;
            armed    = col_q;
        end
        if (lhbl_q && !lhbl) begin
            line_cnt++;
        end
        if (armed) begin
            if (!lhbl || !lvbl) begin
                checks++;
                if ({red, green, blue} !== 24'd0) begin
                    $display("Error at %0t ns: blanked pixel %h", $time, {red, green, blue});
                    errors++;
                end
            end else if (line_cnt >= 1) begin
                checks++;
                if ({red, green, blue} !== exp_rgb) begin
                    $display("Error at %0t ns: pixel %h, expected %h", $time,
                             {red, green, blue}, exp_rgb);
                    errors++;
                end
            end
        end
        // Beam position rebuilt from the blanking edges, two clocks per pixel
        if (lvbl && !lvbl_q) begin
            vline  = 0;
            vknown = 1'b1;
        end else if (!lhbl_q && lhbl) begin
            vline++;
        end
        if (vknown && lhbl_q && !lhbl) begin
            hclk   = 0;
            hknown = 1'b1;
        end else begin
            hclk++;
        end
        if (hknown) begin
            exp_hs = (`H_ACTIVE + hclk / 2 >= `HS_START) && (`H_ACTIVE + hclk / 2 < `HS_END);
            exp_vs = (vline >= `VS_START) && (vline < `VS_END);
            checks++;
            if (hs !== exp_hs || vs !== exp_vs) begin
                $display("Error at %0t ns: hs %b vs %b, expected hs %b vs %b", $time,
                         hs, vs, exp_hs, exp_vs);
                errors++;
            end
        end
        lhbl_q  = lhbl;
        lvbl_q  = lvbl;
        irq_n_q = irq_n;
    end

endmodule

// ==== tests/video_tb.sv ====
// Testbench of the video subsystem
// Clock, reset, tile ROM model, stimulus table, watchdog and final result
`timescale 1ns/1ns
`include "video_settings.svh"

module tile_rom_model(
    input               clk,
    input               rom_cs,
    input        [10:0] rom_addr,
    output logic [31:0] rom_data,
    output logic        rom_ok
);
    int cnt;

    initial begin
        rom_data = '0;
        rom_ok   = 1'b0;
        cnt      = 0;
        void'($urandom(43502));
    end

    // Low nibble of the tile code fills the whole row
    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs && cnt == 0) begin
            cnt = int'($urandom % 3) + 1;
        end else if (cnt == 1) begin
            rom_data = {8{rom_addr[6:3]}};
            rom_ok   = 1'b1;
            cnt      = 0;
        end else if (cnt > 1) begin
            cnt--;
        end
    end
endmodule

module video_tb;
    import video_pkg::*;

    localparam longint FRAME_CLKS = `H_TOTAL * `V_TOTAL * 2;
    localparam longint FRAME_NS   = FRAME_CLKS * 100;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_VIDEO, OP_IRQ, OP_NOIRQ} op_e;
    typedef struct packed {
        op_e         op;
        logic [2:0]  tag;
        logic [9:0]  addr;
        logic [7:0]  data;
        logic [3:0]  frames;
        logic [23:0] rgb;
    } entry_t;

    logic clk = 1'b0, reset = 1'b1, pxl_cen = 1'b0;
    logic wb_cyc = 1'b0, wb_stb = 1'b0, wb_we = 1'b0;
    logic [9:0] wb_adr = '0;
    logic [7:0] wb_dat_w = '0;
    logic [7:0] wb_dat_r;
    logic wb_ack, irq_n, rom_cs, rom_ok;
    logic [10:0] rom_addr;
    logic [31:0] rom_data;
    logic [7:0] red, green, blue;
    logic lhbl, lvbl, hs, vs;
    logic exp_rd = 1'b0, col_check = 1'b0, irq_hi_check = 1'b0;
    logic [7:0] exp_data = '0;
    logic [23:0] exp_rgb = '0;
    logic table_ready = 1'b0;
    entry_t table_q[$];

    video_top dut_i(.*);
    tile_rom_model rom_i(.clk, .rom_cs, .rom_addr, .rom_data, .rom_ok);
    video_monitor mon_i(.clk, .wb_cyc, .wb_stb, .wb_ack, .wb_dat_r, .irq_n, .red, .green,
        .blue, .lhbl, .lvbl, .hs, .vs, .exp_rd, .exp_data, .col_check, .exp_rgb,
        .irq_hi_check);

    initial begin
        forever #50 clk = ~clk;
    end

    always @(negedge clk) pxl_cen <= ~pxl_cen;

    // RGB555 channel to 8 bits by repeating its top bits
    function automatic logic [7:0] widen5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    function automatic logic [23:0] rgb_of(input logic [15:0] e);
        return {widen5(e[14:10]), widen5(e[9:5]), widen5(e[4:0])};
    endfunction

    task automatic add(input op_e op, input int tag, input logic [9:0] a,
                       input logic [7:0] d, input int fr, input logic [23:0] rgb);
        table_q.push_back('{op, 3'(tag), a, d, 4'(fr), rgb});
    endtask

    task automatic fill_map(input logic [7:0] code);
        for (int i = 0; i < `MAP_CELLS; i++) begin
            add(OP_WR, 0, `MAP_BASE + 10'(i), code, 0, 0);
        end
    endtask

    task automatic bus_access(input logic we, input logic [9:0] a, input logic [7:0] d);
        int n;
        @(negedge clk);
        exp_rd   = ~we;
        exp_data = d;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = a;
        wb_dat_w = we ? d : 8'd0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < 4);
        if (!wb_ack) mon_i.note_failure("Bus access got no acknowledge");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_irq();
        longint n;
        n = 0;
        while (irq_n && n < 2 * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (irq_n) mon_i.note_failure("irq_n did not go low during vertical blank");
    endtask

    initial begin
        longint wd;
        wait (table_ready);
        wd = (longint'(table_q.size()) * 2 + 4) * FRAME_NS;
        #(wd);
        $display("Timeout: the test sequence did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        entry_t e;
        int cur;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Register and palette readback
        add(OP_WR, 1, 10'h001, 8'h2A, 0, 0);
        add(OP_RD, 1, 10'h001, 8'h2A, 0, 0);
        add(OP_WR, 1, 10'h002, 8'h15, 0, 0);
        add(OP_RD, 1, 10'h002, 8'h15, 0, 0);
        add(OP_WR, 1, 10'h003, 8'h03, 0, 0);
        add(OP_RD, 1, 10'h003, 8'h03, 0, 0);
        add(OP_WR, 1, 10'h000, 8'h04, 0, 0);
        add(OP_RD, 1, 10'h000, 8'h04, 0, 0);
        add(OP_WR, 1, `PAL_BASE + 10'd6, 8'h12, 0, 0);
        add(OP_WR, 1, `PAL_BASE + 10'd7, 8'h34, 0, 0);
        add(OP_WR, 1, `PAL_BASE + 10'd42, 8'h6B, 0, 0);
        add(OP_WR, 1, `PAL_BASE + 10'd43, 8'h5A, 0, 0);
        add(OP_RD, 1, `PAL_BASE + 10'd6, 8'h12, 0, 0);
        add(OP_RD, 1, `PAL_BASE + 10'd7, 8'h34, 0, 0);
        add(OP_RD, 1, `PAL_BASE + 10'd42, 8'h6B, 0, 0);
        add(OP_RD, 1, `PAL_BASE + 10'd43, 8'h5A, 0, 0);
        add(OP_VIDEO, 2, 0, 0, 2, rgb_of(16'h1234));
        fill_map(8'h05);
        add(OP_WR, 3, 10'h000, 8'h05, 0, 0);
        add(OP_VIDEO, 3, 0, 0, 2, rgb_of(16'h6B5A));
        add(OP_WR, 5, 10'h001, 8'h07, 0, 0);
        add(OP_WR, 5, 10'h002, 8'h33, 0, 0);
        add(OP_VIDEO, 5, 0, 0, 2, rgb_of(16'h6B5A));
        add(OP_RD, 5, `MAP_BASE, 8'h05, 0, 0);
        add(OP_RD, 5, `MAP_BASE + 10'd63, 8'h05, 0, 0);
        fill_map(8'h00);
        add(OP_VIDEO, 4, 0, 0, 2, rgb_of(16'h1234));
        add(OP_WR, 6, 10'h004, 8'h00, 0, 0);
        add(OP_WR, 6, 10'h000, 8'h07, 0, 0);
        add(OP_IRQ, 6, 0, 0, 0, 0);
        add(OP_RD, 6, 10'h004, 8'h01, 0, 0);
        add(OP_WR, 6, 10'h004, 8'h00, 0, 0);
        add(OP_NOIRQ, 6, 0, 0, 0, 0);
        table_ready = 1'b1;
        cur = 1;
        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.tag != 0 && int'(e.tag) != cur) begin
                mon_i.end_test(cur);
                cur = int'(e.tag);
            end
            case (e.op)
                OP_WR: bus_access(1'b1, e.addr, e.data);
                OP_RD: bus_access(1'b0, e.addr, e.data);
                OP_VIDEO: begin
                    exp_rgb   = e.rgb;
                    col_check = 1'b1;
                    repeat (longint'(e.frames) * FRAME_CLKS) @(negedge clk);
                    col_check = 1'b0;
                end
                OP_IRQ: wait_irq();
                default: begin
                    irq_hi_check = 1'b1;
                    repeat (4) @(negedge clk);
                    irq_hi_check = 1'b0;
                end
            endcase
        end
        mon_i.end_test(cur);
        mon_i.report();
        if (mon_i.errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/tile_layer.sv
src/color_mix.sv
src/video_top.sv
tests/video_chk.sv
tests/video_monitor.sv
tests/video_tb.sv
